/* verilog/ht_pkg.sv */
package ht_pkg;

  // Table geometry.
  localparam int KEY_W    = 32;
  localparam int DATA_W   = 32;
  localparam int NUM_BANK = 4;
  localparam int BANK_W   = 2;
  localparam int NUM_ROW  = 16;
  localparam int ROW_W    = 4;

  // Pipeline depths.
  localparam int MEM_DELAY   = 2;
  localparam int HASH_DELAY  = 1;
  localparam int PLINE_DELAY = HASH_DELAY + MEM_DELAY;

  // One stored entry, 65 bits.
  typedef struct packed {
    logic              vld;
    logic [KEY_W-1:0]  key;
    logic [DATA_W-1:0] data;
  } ht_entry_t;

  // Search or update travelling down the pipeline.
  typedef struct packed {
    logic              vld;
    logic              upd;
    logic              del;
    logic [KEY_W-1:0]  key;
    logic [DATA_W-1:0] data;
  } ht_op_t;

  // Hashed row, one per bank.
  typedef struct packed {
    logic [NUM_BANK-1:0][ROW_W-1:0] row;
  } ht_rows_t;

  // Write command shared by all banks.
  typedef struct packed {
    logic [NUM_BANK-1:0] en;
    logic [ROW_W-1:0]    row;
    ht_entry_t           entry;
  } ht_wr_t;

  // Rotate by 3 per bank, then fold the nibbles.
  function automatic logic [ROW_W-1:0] ht_row_hash(input logic [KEY_W-1:0] key,
                                                   input logic [BANK_W-1:0] bank);
    logic [KEY_W-1:0] rot;
    logic [ROW_W-1:0] row;
    int               sh;
    sh  = 3 * int'(bank);
    rot = (key << sh) | (key >> (KEY_W - sh));
    row = '0;
    for (int i = 0; i < KEY_W / ROW_W; i++) begin
      row ^= rot[i*ROW_W +: ROW_W];
    end
    return row;
  endfunction

endpackage

/* verilog/ht_hash.sv */
`timescale 1ns/10ps

module ht_hash (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      ready,
  input  logic                      sr_en,
  input  logic                      up_en,
  input  logic                      up_del,
  input  logic [ht_pkg::KEY_W-1:0]  sr_key,
  input  logic [ht_pkg::KEY_W-1:0]  up_key,
  input  logic [ht_pkg::DATA_W-1:0] up_din,
  input  logic                      up_bp,
  output ht_pkg::ht_op_t            op,
  output ht_pkg::ht_rows_t          rows
);

  // Accept strobes for this cycle.
  logic             sr_acc;
  logic             up_acc;
  // Next operation and its rows.
  ht_pkg::ht_op_t   op_nxt;
  ht_pkg::ht_rows_t rows_nxt;

  // Searches always go when ready.
  assign sr_acc = ready & sr_en;
  // Update waits for a free slot and loses to a search.
  assign up_acc = ready & up_en & ~up_bp & ~sr_en;

  always_comb begin
    op_nxt      = '0;
    op_nxt.vld  = sr_acc | up_acc;
    op_nxt.upd  = up_acc;
    op_nxt.del  = up_acc & up_del;
    // Search key takes priority.
    op_nxt.key  = sr_acc ? sr_key : up_key;
    op_nxt.data = up_din;
  end

  // One hash per bank.
  always_comb begin
    for (int b = 0; b < ht_pkg::NUM_BANK; b++) begin
      rows_nxt.row[b] = ht_pkg::ht_row_hash(op_nxt.key, b[ht_pkg::BANK_W-1:0]);
    end
  end

  // Issue register.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      op <= '0;
    end else begin
      op <= op_nxt;
    end
  end

  // Row addresses follow the op.
  always_ff @(posedge clk) begin
    rows <= rows_nxt;
  end

endmodule

/* verilog/ht_bank_ram.sv */
`timescale 1ns/10ps

module ht_bank_ram (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic [ht_pkg::ROW_W-1:0] rd_row,
  input  logic                     wr_en,
  input  logic [ht_pkg::ROW_W-1:0] wr_row,
  input  ht_pkg::ht_entry_t        wr_entry,
  output ht_pkg::ht_entry_t        rd_entry
);

  // Entry storage, one entry per row.
  ht_pkg::ht_entry_t mem [ht_pkg::NUM_ROW];

  // Read pipeline stages.
  ht_pkg::ht_entry_t rd_q1;
  ht_pkg::ht_entry_t rd_q2;

  // Single write port.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_row] <= wr_entry;
    end
  end

  // Array is sampled at the first edge.
  // A write landing on the same edge is seen by the next read only.
  // This keeps searches issued before up_done on the old table.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_q1 <= '0;
      rd_q2 <= '0;
    end else begin
      rd_q1 <= mem[rd_row];
      rd_q2 <= rd_q1;
    end
  end

  // Second stage drives the bank output.
  assign rd_entry = rd_q2;

endmodule

/* verilog/ht_resolve.sv */
`timescale 1ns/10ps

module ht_resolve (
  input  logic                                         clk,
  input  logic                                         arst_n,
  input  ht_pkg::ht_op_t                               op_in,
  input  ht_pkg::ht_rows_t                             rows_in,
  input  ht_pkg::ht_entry_t [ht_pkg::NUM_BANK-1:0]     entries,
  output logic                                         sr_vld,
  output logic                                         sr_match,
  output logic [ht_pkg::DATA_W-1:0]                    sr_dout,
  output logic                                         upd_vld,
  output ht_pkg::ht_wr_t                               upd_wr,
  output logic                                         up_fail
);

  // Op and rows delayed to line up with bank data.
  ht_pkg::ht_op_t                 op_pipe   [ht_pkg::MEM_DELAY];
  ht_pkg::ht_rows_t               rows_pipe [ht_pkg::MEM_DELAY];
  ht_pkg::ht_op_t                 op_d;
  ht_pkg::ht_rows_t               rows_d;
  // Per-bank compare results.
  logic [ht_pkg::NUM_BANK-1:0]    hit;
  logic [ht_pkg::NUM_BANK-1:0]    free;
  logic                           hit_any;
  logic                           free_any;
  logic [ht_pkg::BANK_W-1:0]      hit_bank;
  logic [ht_pkg::BANK_W-1:0]      free_bank;
  // Update target.
  logic [ht_pkg::BANK_W-1:0]      tgt_bank;
  logic                           tgt_ok;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < ht_pkg::MEM_DELAY; i++) begin
        op_pipe[i] <= '0;
      end
    end else begin
      op_pipe[0] <= op_in;
      for (int i = 1; i < ht_pkg::MEM_DELAY; i++) begin
        op_pipe[i] <= op_pipe[i-1];
      end
    end
  end

  // Rows carry no control.
  always_ff @(posedge clk) begin
    rows_pipe[0] <= rows_in;
    for (int i = 1; i < ht_pkg::MEM_DELAY; i++) begin
      rows_pipe[i] <= rows_pipe[i-1];
    end
  end

  assign op_d   = op_pipe[ht_pkg::MEM_DELAY-1];
  assign rows_d = rows_pipe[ht_pkg::MEM_DELAY-1];

  // Scan high to low so the lowest bank wins.
  always_comb begin
    hit_any   = 1'b0;
    free_any  = 1'b0;
    hit_bank  = '0;
    free_bank = '0;
    for (int b = ht_pkg::NUM_BANK - 1; b >= 0; b--) begin
      hit[b]  = entries[b].vld && (entries[b].key == op_d.key);
      free[b] = !entries[b].vld;
      if (hit[b]) begin
        hit_any  = 1'b1;
        hit_bank = b[ht_pkg::BANK_W-1:0];
      end
      if (free[b]) begin
        free_any  = 1'b1;
        free_bank = b[ht_pkg::BANK_W-1:0];
      end
    end
  end

  // Search result.
  assign sr_vld   = op_d.vld & ~op_d.upd;
  assign sr_match = sr_vld & hit_any;
  assign sr_dout  = entries[hit_bank].data;

  assign upd_vld = op_d.vld & op_d.upd;

  always_comb begin
    tgt_ok   = 1'b0;
    tgt_bank = hit_bank;
    up_fail  = 1'b0;
    if (op_d.del) begin
      // Absent key on delete is a no-op.
      tgt_ok = hit_any;
    end else if (hit_any) begin
      tgt_ok = 1'b1;
    end else if (free_any) begin
      tgt_ok   = 1'b1;
      tgt_bank = free_bank;
    end else begin
      // All candidate rows taken.
      up_fail = upd_vld;
    end
    upd_wr               = '0;
    upd_wr.en[tgt_bank]  = upd_vld & tgt_ok;
    upd_wr.row           = rows_d.row[tgt_bank];
    upd_wr.entry.vld     = ~op_d.del;
    upd_wr.entry.key     = op_d.del ? '0 : op_d.key;
    upd_wr.entry.data    = op_d.del ? '0 : op_d.data;
  end

endmodule

/* verilog/ht_update_ctrl.sv */
`timescale 1ns/10ps

module ht_update_ctrl (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           up_accept,
  input  logic           upd_vld,
  input  ht_pkg::ht_wr_t upd_wr,
  output logic           ready,
  output logic           up_bp,
  output logic           up_done,
  output ht_pkg::ht_wr_t wr
);

  // Clear the table, then serve.
  typedef enum logic [1:0] {
    ST_SWEEP,
    ST_RUN
  } state_t;

  state_t                   state;
  // Row being cleared.
  logic [ht_pkg::ROW_W-1:0] sweep_row;
  // Update in flight past the issue stage.
  logic                     busy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= ST_SWEEP;
      sweep_row <= '0;
    end else begin
      case (state)
        ST_SWEEP: begin
          // One row of every bank per cycle.
          sweep_row <= sweep_row + 1'b1;
          if (sweep_row == ht_pkg::ROW_W'(ht_pkg::NUM_ROW - 1)) begin
            state <= ST_RUN;
          end
        end
        default: begin
          state <= ST_RUN;
        end
      endcase
    end
  end

  assign ready = (state == ST_RUN);

  // Set by the issued update, cleared when its result comes back.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy <= 1'b0;
    end else begin
      busy <= (busy | up_accept) & ~upd_vld;
    end
  end

  // Hold off updates until the table is clean and idle.
  assign up_bp = ~ready | up_accept | busy;

  // Done lines up with the write.
  assign up_done = upd_vld;

  always_comb begin
    wr = '0;
    if (state == ST_SWEEP) begin
      // Invalid entry in every bank.
      wr.en    = '1;
      wr.row   = sweep_row;
      wr.entry = '0;
    end else if (upd_vld) begin
      wr = upd_wr;
    end
  end

endmodule

/* verilog/hash_table.sv */
`timescale 1ns/10ps

module hash_table (
  input  logic                      clk,
  input  logic                      arst_n,
  // Search port.
  input  logic                      sr_en,
  input  logic [ht_pkg::KEY_W-1:0]  sr_key,
  output logic                      sr_vld,
  output logic                      sr_match,
  output logic [ht_pkg::DATA_W-1:0] sr_dout,
  // Update port.
  input  logic                      up_en,
  input  logic [ht_pkg::KEY_W-1:0]  up_key,
  input  logic [ht_pkg::DATA_W-1:0] up_din,
  input  logic                      up_del,
  output logic                      up_bp,
  output logic                      up_done,
  output logic                      up_fail,
  // Table cleared.
  output logic                      ready
);

  // Issue stage outputs.
  ht_pkg::ht_op_t                           op;
  ht_pkg::ht_rows_t                         rows;
  // Bank read data.
  ht_pkg::ht_entry_t [ht_pkg::NUM_BANK-1:0] entries;
  // Update path.
  logic                                     upd_vld;
  ht_pkg::ht_wr_t                           upd_wr;
  ht_pkg::ht_wr_t                           wr;
  logic                                     up_accept;

  // Update held in the issue register.
  assign up_accept = op.vld & op.upd;

  ht_hash ht_hash_i (
    .clk    (clk),
    .arst_n (arst_n),
    .ready  (ready),
    .sr_en  (sr_en),
    .up_en  (up_en),
    .up_del (up_del),
    .sr_key (sr_key),
    .up_key (up_key),
    .up_din (up_din),
    .up_bp  (up_bp),
    .op     (op),
    .rows   (rows)
  );

  // One memory per bank.
  for (genvar b = 0; b < ht_pkg::NUM_BANK; b++) begin : g_bank
    ht_bank_ram ht_bank_ram_i (
      .clk      (clk),
      .arst_n   (arst_n),
      .rd_row   (rows.row[b]),
      .wr_en    (wr.en[b]),
      .wr_row   (wr.row),
      .wr_entry (wr.entry),
      .rd_entry (entries[b])
    );
  end

  ht_resolve ht_resolve_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .op_in    (op),
    .rows_in  (rows),
    .entries  (entries),
    .sr_vld   (sr_vld),
    .sr_match (sr_match),
    .sr_dout  (sr_dout),
    .upd_vld  (upd_vld),
    .upd_wr   (upd_wr),
    .up_fail  (up_fail)
  );

  ht_update_ctrl ht_update_ctrl_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .up_accept (up_accept),
    .upd_vld   (upd_vld),
    .upd_wr    (upd_wr),
    .ready     (ready),
    .up_bp     (up_bp),
    .up_done   (up_done),
    .wr        (wr)
  );

endmodule

/* sim/hash_table_tb.sv */
`timescale 1ns/10ps

module hash_table_tb;

  localparam int CLK_HALF      = 50;
  localparam int DRIVE_DLY     = 10;
  localparam int READY_TIMEOUT = 40;
  localparam int IDLE_TIMEOUT  = 20;
  localparam int UPD_TIMEOUT   = 30;
  localparam int RAND_CYCLES   = 800;
  localparam int POOL_N        = 32;

  // Predicted outcome of one operation.
  typedef struct packed {
    logic                      match;
    logic [ht_pkg::DATA_W-1:0] data;
    logic                      fail;
    logic                      wr;
    logic [ht_pkg::BANK_W-1:0] bank;
  } result_t;

  // Accepted search and its prediction.
  typedef struct packed {
    int                        cyc;
    logic                      match;
    logic [ht_pkg::DATA_W-1:0] data;
  } srch_t;

  // Accepted update.
  typedef struct packed {
    int                        cyc;
    logic                      del;
    logic [ht_pkg::KEY_W-1:0]  key;
    logic [ht_pkg::DATA_W-1:0] data;
  } updt_t;

  logic                      clk;
  logic                      arst_n;
  logic                      sr_en;
  logic [ht_pkg::KEY_W-1:0]  sr_key;
  logic                      sr_vld;
  logic                      sr_match;
  logic [ht_pkg::DATA_W-1:0] sr_dout;
  logic                      up_en;
  logic [ht_pkg::KEY_W-1:0]  up_key;
  logic [ht_pkg::DATA_W-1:0] up_din;
  logic                      up_del;
  logic                      up_bp;
  logic                      up_done;
  logic                      up_fail;
  logic                      ready;

  // Model of the four banks.
  ht_pkg::ht_entry_t         model [ht_pkg::NUM_BANK][ht_pkg::NUM_ROW];
  srch_t                     srch_q [$];
  updt_t                     upd_q [$];
  int                        cyc;
  int                        fail_cnt;
  int                        checked_cnt;
  string                     test_name;
  integer                    seed;
  // Small key pool, so rows collide.
  logic [ht_pkg::KEY_W-1:0]  pool [POOL_N];

  initial begin
    clk = 1'b0;
    forever begin
      #CLK_HALF clk = ~clk;
    end
  end

  hash_table hash_table_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .sr_en    (sr_en),
    .sr_key   (sr_key),
    .sr_vld   (sr_vld),
    .sr_match (sr_match),
    .sr_dout  (sr_dout),
    .up_en    (up_en),
    .up_key   (up_key),
    .up_din   (up_din),
    .up_del   (up_del),
    .up_bp    (up_bp),
    .up_done  (up_done),
    .up_fail  (up_fail),
    .ready    (ready)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic wrong_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    $display("mismatch %s %s expected %h actual %h", test_name, what, exp, act);
    abort_run("value check failed");
  endtask

  // Search hits the valid key, insert takes the lowest free bank.
  function automatic result_t predict_result(input logic [ht_pkg::KEY_W-1:0] key,
                                             input logic upd, input logic del);
    result_t                  res;
    logic [ht_pkg::ROW_W-1:0] row;
    logic                     found;
    logic                     has_free;
    logic [ht_pkg::BANK_W-1:0] found_bank;
    logic [ht_pkg::BANK_W-1:0] free_bank;
    res        = '0;
    found      = 1'b0;
    has_free   = 1'b0;
    found_bank = '0;
    free_bank  = '0;
    for (int b = 0; b < ht_pkg::NUM_BANK; b++) begin
      row = ht_pkg::ht_row_hash(key, ht_pkg::BANK_W'(b));
      if (model[b][row].vld && model[b][row].key == key) begin
        found      = 1'b1;
        found_bank = ht_pkg::BANK_W'(b);
        res.data   = model[b][row].data;
      end else if (!model[b][row].vld && !has_free) begin
        has_free  = 1'b1;
        free_bank = ht_pkg::BANK_W'(b);
      end
    end
    res.match = found & ~upd;
    if (upd) begin
      // Delete of a missing key writes nothing.
      res.wr   = found | (~del & has_free);
      res.bank = found ? found_bank : free_bank;
      res.fail = ~del & ~found & ~has_free;
    end
    return res;
  endfunction

  task automatic update_model(input updt_t u, input result_t res);
    logic [ht_pkg::ROW_W-1:0] row;
    if (res.wr) begin
      row = ht_pkg::ht_row_hash(u.key, res.bank);
      model[res.bank][row].vld  = ~u.del;
      model[res.bank][row].key  = u.key;
      model[res.bank][row].data = u.data;
    end
  endtask

  // Mid-cycle sampling, inputs and outputs both settled.
  always @(negedge clk) begin : compare
    srch_t   s;
    updt_t   u;
    result_t e;
    logic    exp_ready;
    logic    exp_bp;
    if (!arst_n) begin
      // Table is empty after the sweep.
      for (int b = 0; b < ht_pkg::NUM_BANK; b++) begin
        for (int r = 0; r < ht_pkg::NUM_ROW; r++) begin
          model[b][r] = '0;
        end
      end
      srch_q.delete();
      upd_q.delete();
      cyc = 0;
    end else begin
      cyc++;
      // Sweep clears one row per cycle.
      exp_ready = (cyc > ht_pkg::NUM_ROW);
      assert (ready == exp_ready) else wrong_value("ready", 32'(exp_ready), 32'(ready));
      // Held from acceptance until the result.
      exp_bp = ~exp_ready | (upd_q.size() != 0);
      assert (up_bp == exp_bp) else wrong_value("up_bp", 32'(exp_bp), 32'(up_bp));
      if (up_done) begin
        assert (upd_q.size() != 0) else abort_run("up_done without an accepted update");
        u = upd_q.pop_front();
        assert (cyc == u.cyc + ht_pkg::PLINE_DELAY)
          else wrong_value("up_done cycle", 32'(u.cyc + ht_pkg::PLINE_DELAY), 32'(cyc));
        e = predict_result(u.key, 1'b1, u.del);
        assert (up_fail == e.fail) else wrong_value("up_fail", 32'(e.fail), 32'(up_fail));
        if (up_fail) begin
          fail_cnt++;
        end
        update_model(u, e);
        checked_cnt++;
      end
      if (sr_vld) begin
        assert (srch_q.size() != 0) else abort_run("sr_vld without an accepted search");
        s = srch_q.pop_front();
        assert (cyc == s.cyc + ht_pkg::PLINE_DELAY)
          else wrong_value("sr_vld cycle", 32'(s.cyc + ht_pkg::PLINE_DELAY), 32'(cyc));
        assert (sr_match == s.match)
          else wrong_value("sr_match", 32'(s.match), 32'(sr_match));
        if (s.match) begin
          assert (sr_dout == s.data) else wrong_value("sr_dout", s.data, sr_dout);
        end
        checked_cnt++;
      end
      if (srch_q.size() != 0) begin
        assert (cyc < srch_q[0].cyc + ht_pkg::PLINE_DELAY)
          else abort_run("search result never arrived");
      end
      if (upd_q.size() != 0) begin
        assert (cyc < upd_q[0].cyc + ht_pkg::PLINE_DELAY)
          else abort_run("update result never arrived");
      end
      // Searches in the up_done cycle already see the new model.
      if (exp_ready && sr_en) begin
        e       = predict_result(sr_key, 1'b0, 1'b0);
        s.cyc   = cyc;
        s.match = e.match;
        s.data  = e.data;
        srch_q.push_back(s);
      end
      if (exp_ready && up_en && !exp_bp && !sr_en) begin
        u.cyc  = cyc;
        u.del  = up_del;
        u.key  = up_key;
        u.data = up_din;
        upd_q.push_back(u);
      end
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic search_key(input logic [ht_pkg::KEY_W-1:0] key);
    sr_en  = 1'b1;
    sr_key = key;
    next_cycle();
    sr_en  = 1'b0;
  endtask

  // Hold the request until the DUT takes it.
  task automatic send_update(input logic [ht_pkg::KEY_W-1:0] key,
                             input logic [ht_pkg::DATA_W-1:0] data, input logic del);
    logic acc;
    int   n;
    up_en  = 1'b1;
    up_key = key;
    up_din = data;
    up_del = del;
    acc    = 1'b0;
    n      = 0;
    while (!acc) begin
      acc = ready & ~up_bp & ~sr_en;
      next_cycle();
      n++;
      if (!acc && n > UPD_TIMEOUT) begin
        abort_run("update never accepted");
      end
    end
    up_en = 1'b0;
  endtask

  task automatic drain_pipeline();
    int n;
    n = 0;
    while (srch_q.size() != 0 || upd_q.size() != 0 || up_bp) begin
      next_cycle();
      n++;
      if (n > IDLE_TIMEOUT) begin
        abort_run("pipeline did not drain");
      end
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!ready) begin
      next_cycle();
      n++;
      if (n > READY_TIMEOUT) begin
        abort_run("ready did not rise after reset");
      end
    end
  endtask

  initial begin : stimulus
    logic [31:0]              r;
    logic [ht_pkg::KEY_W-1:0] ck [5];
    int                       base_fails;
    seed      = 32'h0a16_efb5;
    arst_n    = 1'b0;
    sr_en     = 1'b0;
    sr_key    = '0;
    up_en     = 1'b0;
    up_key    = '0;
    up_din    = '0;
    up_del    = 1'b0;
    test_name = "reset";
    for (int i = 0; i < POOL_N; i++) begin
      pool[i] = $random(seed);
    end
    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    arst_n = 1'b1;
    wait_ready();
    // Empty table, every search misses.
    for (int i = 0; i < 8; i++) begin
      search_key(pool[i]);
    end
    drain_pipeline();

    test_name = "insert";
    for (int i = 0; i < 6; i++) begin
      send_update(pool[i], $random(seed), 1'b0);
    end
    for (int i = 0; i < 6; i++) begin
      search_key(pool[i]);
    end
    send_update(pool[2], 32'h7777_0002, 1'b0);
    search_key(pool[2]);
    drain_pipeline();
    // Overwritten key reads back the new data.
    search_key(pool[2]);
    drain_pipeline();

    test_name = "delete";
    for (int i = 0; i < 6; i++) begin
      send_update(pool[i], '0, 1'b1);
    end
    send_update(pool[20], '0, 1'b1);
    for (int i = 0; i < 6; i++) begin
      search_key(pool[i]);
    end
    drain_pipeline();

    test_name = "overflow";
    // Flipping two bits four apart keeps every row.
    ck[0] = 32'h5a5a_0f00;
    ck[1] = ck[0] ^ 32'h0000_0011;
    ck[2] = ck[0] ^ 32'h0000_0022;
    ck[3] = ck[0] ^ 32'h0000_0033;
    ck[4] = ck[0] ^ 32'h0000_0044;
    base_fails = fail_cnt;
    for (int i = 0; i < 5; i++) begin
      send_update(ck[i], 32'h4400_0000 + 32'(i), 1'b0);
    end
    for (int i = 0; i < 5; i++) begin
      search_key(ck[i]);
    end
    drain_pipeline();
    assert (fail_cnt == base_fails + 1)
      else wrong_value("overflow fails", 32'(base_fails + 1), 32'(fail_cnt));

    test_name = "bypass";
    // Search and update together, the search goes first.
    up_en  = 1'b1;
    up_key = ck[0];
    up_din = 32'h5500_00aa;
    up_del = 1'b0;
    sr_en  = 1'b1;
    sr_key = ck[0];
    next_cycle();
    sr_en = 1'b0;
    assert (ready && !up_bp) else abort_run("update slot busy when idle");
    next_cycle();
    // Second update collides with searches and up_bp.
    up_key = ck[1];
    up_del = 1'b1;
    sr_en  = 1'b1;
    repeat (6) next_cycle();
    sr_en = 1'b0;
    send_update(ck[1], '0, 1'b1);
    search_key(ck[0]);
    search_key(ck[1]);
    drain_pipeline();

    test_name = "random";
    for (int n = 0; n < RAND_CYCLES; n++) begin
      r      = $random(seed);
      sr_en  = r[0];
      sr_key = pool[r[12:8]];
      if (!up_en && r[17:16] == 2'b00) begin
        up_en  = 1'b1;
        up_key = pool[r[25:21]];
        up_del = (r[20:19] == 2'b00);
        up_din = $random(seed);
      end
      r[31] = ready & up_en & ~up_bp & ~sr_en;
      next_cycle();
      if (r[31]) begin
        up_en = 1'b0;
      end
    end
    sr_en = 1'b0;
    up_en = 1'b0;

    test_name = "end";
    drain_pipeline();
    if (checked_cnt > 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      abort_run("no result was checked");
    end
  end

endmodule

/* hash_table.f */
verilog/ht_pkg.sv
verilog/ht_hash.sv
verilog/ht_bank_ram.sv
verilog/ht_resolve.sv
verilog/ht_update_ctrl.sv
verilog/hash_table.sv
sim/hash_table_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -j 0 -Mdir obj_dir --top-module hash_table_tb -f hash_table.f

run: build
	./obj_dir/Vhash_table_tb | tee $(LOG)
	grep -q "Everything OK" $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module hash_table -f hash_table.f

clean:
	rm -rf obj_dir $(LOG)
